/* include/rename_core_cfg.svh */
// size macros for the rename core, included by every rtl file and the testbench
`ifndef RENAME_CORE_CFG_SVH
`define RENAME_CORE_CFG_SVH

// ==================================================
// architectural side
// ==================================================
`define AREG_NUM	32		// alpha integer registers
`define AREG_W		5		// arch index width
`define ZERO_REG	5'd31	// r31 reads zero, never renamed

// ==================================================
// physical side
// ==================================================
`define PREG_NUM	40		// 32 mapped + 8 spare tags
`define PREG_W		6		// physical tag width

// reorder buffer
`define ROB_DEPTH	16
`define ROB_IDX_W	4		// log2 of ROB_DEPTH

`endif

/* source/rename_pkg.sv */
// types shared by dispatch, rob and the testbench, import with rename_pkg::*
`include "rename_core_cfg.svh"

package rename_pkg;

	// operate format, dest in rc
	typedef struct packed {
		logic	[5:0]			opcode;
		logic	[`AREG_W-1:0]	ra;
		logic	[`AREG_W-1:0]	rb;
		logic	[10:0]			func;	// sbz + lit flag + function code
		logic	[`AREG_W-1:0]	rc;
	} op_fmt_t;

	// memory format, ra is data reg, rb is base
	typedef struct packed {
		logic	[5:0]			opcode;
		logic	[`AREG_W-1:0]	ra;
		logic	[`AREG_W-1:0]	rb;
		logic	[15:0]			disp;
	} mem_fmt_t;

	// one instruction word, two views
	typedef union packed {
		op_fmt_t	op;
		mem_fmt_t	mem;
	} inst_u;

	typedef enum logic [1:0] {
		CLASS_OP	= 2'd0,	// int operate, 0x10..0x13
		CLASS_LOAD	= 2'd1,	// ldq / ldq_u style
		CLASS_STORE	= 2'd2,	// no dest
		CLASS_OTHER	= 2'd3	// everything else, no dest
	} inst_class_e;

	// one rob slot
	typedef struct packed {
		logic	[`AREG_W-1:0]	dest_areg;
		logic	[`PREG_W-1:0]	new_preg;	// Tnew
		logic	[`PREG_W-1:0]	old_preg;	// Told, freed at retire
		logic					has_dest;
		logic					done;
	} rob_entry_t;

endpackage

/* source/dispatch_if.sv */
// one dispatch event shared by dispatch stage, map table, free list and rob
`timescale 1ns/100ps
`include "rename_core_cfg.svh"

interface dispatch_if;

	logic					dsp_en;		// one inst renamed this cycle
	logic					dest_vld;	// needs a fresh tag
	logic	[`AREG_W-1:0]	dest_areg;
	logic	[`AREG_W-1:0]	opa_areg;
	logic	[`AREG_W-1:0]	opb_areg;
	logic	[`PREG_W-1:0]	new_preg;	// free list head
	logic	[`PREG_W-1:0]	old_preg;	// current map of dest_areg

	// decode side
	modport dispatcher (output dsp_en, dest_vld, dest_areg, opa_areg, opb_areg);
	// free list, offers head tag
	modport allocator (input dsp_en, dest_vld, output new_preg);
	// map table, looks up and renames
	modport renamer (input dsp_en, dest_vld, dest_areg, opa_areg, opb_areg, new_preg,
		output old_preg);
	// rob only records
	modport recorder (input dsp_en, dest_vld, dest_areg, new_preg, old_preg);

endinterface

/* source/dispatch_stage.sv */
// decodes the incoming alpha word and decides whether it dispatches this cycle
`timescale 1ns/100ps
`include "rename_core_cfg.svh"

module dispatch_stage (
	input	logic					inst_vld_i,
	input	rename_pkg::inst_u		inst_i,
	input	logic					rob_full_i,
	input	logic					free_empty_i,
	output	logic					dsp_ack_o,
	dispatch_if.dispatcher			dsp
);
	import rename_pkg::*;

	inst_class_e			inst_class;
	logic					class_has_dest;	// class names a dest at all
	logic	[`AREG_W-1:0]	dest_sel;

	// ==================================================
	// opcode class
	// ==================================================
	always_comb begin
		case (inst_i.op.opcode)
			6'h10, 6'h11, 6'h12, 6'h13:	inst_class = CLASS_OP;
			6'h28, 6'h29:				inst_class = CLASS_LOAD;
			6'h2C, 6'h2D:				inst_class = CLASS_STORE;
			default:					inst_class = CLASS_OTHER;
		endcase
	end

	// field select per format, ra and rb sit at the same bits in both
	always_comb begin
		class_has_dest	= 1'b0;
		dest_sel		= inst_i.mem.ra;	// load dest
		dsp.opa_areg	= inst_i.mem.ra;	// op / store data / other
		dsp.opb_areg	= inst_i.mem.rb;	// base reg or second operand
		case (inst_class)
			CLASS_OP: begin
				class_has_dest	= 1'b1;
				dest_sel		= inst_i.op.rc;
			end
			CLASS_LOAD:	class_has_dest = 1'b1;
			default:	class_has_dest = 1'b0;	// store, other
		endcase
	end

	assign dsp.dest_areg	= dest_sel;
	assign dsp.dest_vld		= class_has_dest && (dest_sel != `ZERO_REG); // r31 keeps its tag

	// ==================================================
	// stall decision
	// ==================================================
	// no tag needed -> free list state does not matter
	assign dsp.dsp_en	= inst_vld_i && !rob_full_i && (!free_empty_i || !dsp.dest_vld);
	assign dsp_ack_o	= dsp.dsp_en;

endmodule: dispatch_stage

/* source/map_table.sv */
// speculative arch to physical map, read combinationally and renamed at the edge
`timescale 1ns/100ps
`include "rename_core_cfg.svh"

module map_table (
	input	logic					clk,
	input	logic					rst_n_i,
	dispatch_if.renamer				dsp,
	output	logic	[`PREG_W-1:0]	opa_preg_o,
	output	logic	[`PREG_W-1:0]	opb_preg_o
);
	localparam int TAG_W = `PREG_W;

	logic	[`PREG_W-1:0]	map_q [`AREG_NUM];	// one tag per arch reg

	// lookups, all from current state
	assign opa_preg_o	= map_q[dsp.opa_areg];
	assign opb_preg_o	= map_q[dsp.opb_areg];
	assign dsp.old_preg	= map_q[dsp.dest_areg];	// Told into rob

	// ==================================================
	// rename write
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			// identity, r -> tag r
			for (int i = 0; i < `AREG_NUM; i++) begin
				map_q[i] <= TAG_W'(i);
			end
		end else if (dsp.dsp_en && dsp.dest_vld) begin
			map_q[dsp.dest_areg] <= dsp.new_preg;	// Tnew
		end
	end

endmodule: map_table

/* source/free_list.sv */
// circular queue of unmapped physical tags, popped at rename and refilled at retire
`timescale 1ns/100ps
`include "rename_core_cfg.svh"

module free_list (
	input	logic					clk,
	input	logic					rst_n_i,
	dispatch_if.allocator			dsp,
	input	logic					retire_vld_i,		// rob frees a Told
	input	logic	[`PREG_W-1:0]	retire_free_preg_i,
	output	logic					free_empty_o
);
	localparam int FL_NUM	= `PREG_NUM - `AREG_NUM;	// spare tags
	localparam int PTR_W	= $clog2(FL_NUM);
	localparam int CNT_W	= $clog2(FL_NUM + 1);
	localparam int TAG_W	= `PREG_W;
	localparam logic [PTR_W-1:0] LAST = PTR_W'(FL_NUM - 1);

	logic	[`PREG_W-1:0]	slot_q [FL_NUM];
	logic	[PTR_W-1:0]		head_q;		// next tag handed out
	logic	[PTR_W-1:0]		tail_q;		// next free slot for a returned tag
	logic	[CNT_W-1:0]		count_q;
	logic					pop;
	logic					push;

	assign pop			= dsp.dsp_en && dsp.dest_vld;
	assign push			= retire_vld_i;
	assign dsp.new_preg	= slot_q[head_q];
	assign free_empty_o	= (count_q == '0);

	// ==================================================
	// queue update, pop and push may coincide
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < FL_NUM; i++) begin
				slot_q[i] <= TAG_W'(`AREG_NUM + i);	// tags 32..39
			end
			head_q	<= '0;
			tail_q	<= '0;	// full, tail sits on head
			count_q	<= CNT_W'(FL_NUM);
		end else begin
			if (pop) begin
				head_q <= (head_q == LAST) ? '0 : head_q + PTR_W'(1);
			end
			if (push) begin
				slot_q[tail_q]	<= retire_free_preg_i;
				tail_q			<= (tail_q == LAST) ? '0 : tail_q + PTR_W'(1);
			end
			case ({push, pop})
				2'b10:		count_q <= count_q + CNT_W'(1);
				2'b01:		count_q <= count_q - CNT_W'(1);
				default:	count_q <= count_q;	// none or both
			endcase
		end
	end

endmodule: free_list

/* source/rob.sv */
// reorder buffer, records each rename, marks completions and retires in program order
`timescale 1ns/100ps
`include "rename_core_cfg.svh"

module rob (
	input	logic						clk,
	input	logic						rst_n_i,
	dispatch_if.recorder				dsp,
	input	logic						cmpl_vld_i,			// execution done strobe
	input	logic	[`ROB_IDX_W-1:0]	cmpl_rob_idx_i,
	output	logic						rob_full_o,
	output	logic	[`ROB_IDX_W-1:0]	tail_idx_o,			// slot of the inst now dispatching
	output	logic						retire_vld_o,
	output	logic	[`AREG_W-1:0]		retire_areg_o,		// committed mapping
	output	logic	[`PREG_W-1:0]		retire_preg_o,
	output	logic	[`PREG_W-1:0]		retire_free_preg_o,	// Told back to free list
	output	logic						retire_free_vld_o
);
	import rename_pkg::*;

	localparam int IDX_W = `ROB_IDX_W;
	localparam int CNT_W = `ROB_IDX_W + 1;

	rob_entry_t				entry_q [`ROB_DEPTH];
	rob_entry_t				new_entry;
	rob_entry_t				head_entry;
	logic	[IDX_W-1:0]		head_q;
	logic	[IDX_W-1:0]		tail_q;
	logic	[CNT_W-1:0]		count_q;	// occupied slots

	// ==================================================
	// dispatch side
	// ==================================================
	always_comb begin
		new_entry			= '0;
		new_entry.dest_areg	= dsp.dest_areg;
		new_entry.new_preg	= dsp.new_preg;
		new_entry.old_preg	= dsp.old_preg;
		new_entry.has_dest	= dsp.dest_vld;
		new_entry.done		= 1'b0;	// set later by completion
	end

	assign rob_full_o	= (count_q == CNT_W'(`ROB_DEPTH));
	assign tail_idx_o	= tail_q;

	// ==================================================
	// retire side, head only
	// ==================================================
	assign head_entry			= entry_q[head_q];
	assign retire_vld_o			= (count_q != '0) && head_entry.done;
	assign retire_areg_o		= head_entry.dest_areg;
	assign retire_preg_o		= head_entry.new_preg;
	assign retire_free_preg_o	= head_entry.old_preg;
	assign retire_free_vld_o	= retire_vld_o && head_entry.has_dest; // stores free nothing

	// slot storage, occupancy comes from count_q
	always_ff @(posedge clk) begin
		if (dsp.dsp_en) begin
			entry_q[tail_q] <= new_entry;
		end
		if (cmpl_vld_i) begin
			entry_q[cmpl_rob_idx_i].done <= 1'b1;	// never the slot being written
		end
	end

	// pointers, depth is a power of two so they wrap on their own
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			head_q	<= '0;
			tail_q	<= '0;
			count_q	<= '0;
		end else begin
			if (dsp.dsp_en) begin
				tail_q <= tail_q + IDX_W'(1);
			end
			if (retire_vld_o) begin
				head_q <= head_q + IDX_W'(1);	// pop after retire
			end
			case ({dsp.dsp_en, retire_vld_o})
				2'b10:		count_q <= count_q + CNT_W'(1);
				2'b01:		count_q <= count_q - CNT_W'(1);
				default:	count_q <= count_q;
			endcase
		end
	end

endmodule: rob

/* source/rename_core.sv */
// rename slice top, connects dispatch stage, map table, free list and rob to the pins
`timescale 1ns/100ps
`include "rename_core_cfg.svh"

module rename_core (
	input	logic						clk,
	input	logic						rst_n_i,

	input	logic						inst_vld_i,			// hold word until ack
	input	logic	[31:0]				inst_i,
	output	logic						dsp_ack_o,
	output	logic	[`PREG_W-1:0]		dsp_opa_preg_o,
	output	logic	[`PREG_W-1:0]		dsp_opb_preg_o,
	output	logic	[`PREG_W-1:0]		dsp_dest_preg_o,	// only with a dest
	output	logic	[`ROB_IDX_W-1:0]	dsp_rob_idx_o,

	input	logic						cmpl_vld_i,
	input	logic	[`ROB_IDX_W-1:0]	cmpl_rob_idx_i,

	output	logic						retire_vld_o,
	output	logic	[`AREG_W-1:0]		retire_areg_o,
	output	logic	[`PREG_W-1:0]		retire_preg_o,
	output	logic	[`PREG_W-1:0]		retire_free_preg_o,
	output	logic						retire_free_vld_o
);

	// ==================================================
	// internal wires
	// ==================================================
	dispatch_if	dsp_if ();	// one rename event

	logic	rob_full;		// rob -> dispatch stall
	logic	free_empty;		// free list -> dispatch stall

	assign dsp_dest_preg_o = dsp_if.new_preg;	// Tnew, head of free list

	// ==================================================
	// instances
	// ==================================================
	dispatch_stage i_dispatch_stage (
		.inst_vld_i			(inst_vld_i),
		.inst_i				(inst_i),
		.rob_full_i			(rob_full),
		.free_empty_i		(free_empty),
		.dsp_ack_o			(dsp_ack_o),
		.dsp				(dsp_if.dispatcher)
	);

	map_table i_map_table (
		.clk				(clk),
		.rst_n_i			(rst_n_i),
		.dsp				(dsp_if.renamer),
		.opa_preg_o			(dsp_opa_preg_o),
		.opb_preg_o			(dsp_opb_preg_o)
	);

	free_list i_free_list (
		.clk				(clk),
		.rst_n_i			(rst_n_i),
		.dsp				(dsp_if.allocator),
		.retire_vld_i		(retire_free_vld_o),	// only entries that took a tag
		.retire_free_preg_i	(retire_free_preg_o),
		.free_empty_o		(free_empty)
	);

	rob i_rob (
		.clk				(clk),
		.rst_n_i			(rst_n_i),
		.dsp				(dsp_if.recorder),
		.cmpl_vld_i			(cmpl_vld_i),
		.cmpl_rob_idx_i		(cmpl_rob_idx_i),
		.rob_full_o			(rob_full),
		.tail_idx_o			(dsp_rob_idx_o),
		.retire_vld_o		(retire_vld_o),
		.retire_areg_o		(retire_areg_o),
		.retire_preg_o		(retire_preg_o),
		.retire_free_preg_o	(retire_free_preg_o),
		.retire_free_vld_o	(retire_free_vld_o)
	);

endmodule: rename_core

/* bench/clk_gen.sv */
// testbench clock and reset source, 8 ns period with reset low for the first 4 rising edges
`timescale 1ns/100ps

module clk_gen (
	output	logic	clk_o,
	output	logic	rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;	// 8 ns period
	end

	initial begin
		rst_n_o = 1'b0;	// sync reset, sampled by the dut on 4 edges
		repeat (4) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule: clk_gen

/* bench/rename_core_assert.sv */
// concurrent checks on rob retire and full behavior, attached to every rob instance by bind
`timescale 1ns/100ps
`include "rename_core_cfg.svh"

module rename_core_assert (
	input	logic						clk_i,
	input	logic						rst_n_i,
	input	logic						rob_full_i,
	input	logic	[`ROB_IDX_W-1:0]	tail_idx_i,
	input	logic	[`ROB_IDX_W-1:0]	head_idx_i,		// slot that retires next
	input	logic						cmpl_vld_i,
	input	logic	[`ROB_IDX_W-1:0]	cmpl_rob_idx_i,
	input	logic						retire_vld_i
);

	logic	[`ROB_DEPTH-1:0]	done_seen;	// completion strobes per slot

	// shadow of the done flags, built from the completion port alone
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			done_seen <= '0;
		end else begin
			if (retire_vld_i) begin
				done_seen[head_idx_i] <= 1'b0;	// slot free again
			end
			if (cmpl_vld_i) begin
				done_seen[cmpl_rob_idx_i] <= 1'b1;
			end
		end
	end

	// ==================================================
	// retire side
	// ==================================================
	a_retire_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		retire_vld_i |-> done_seen[head_idx_i])
		else $error("retire asserted on a head entry that is not done");

	// pointers together and not full means empty
	a_retire_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		((head_idx_i == tail_idx_i) && !rob_full_i) |-> !retire_vld_i)
		else $error("retire asserted while the rob is empty");

	// a dispatch while full would move the tail
	a_no_dsp_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rob_full_i |=> $stable(tail_idx_i))
		else $error("tail moved after a cycle with the rob full");

endmodule: rename_core_assert

bind rob rename_core_assert i_rename_core_assert (
	.clk_i			(clk),
	.rst_n_i		(rst_n_i),
	.rob_full_i		(rob_full_o),
	.tail_idx_i		(tail_idx_o),
	.head_idx_i		(head_q),
	.cmpl_vld_i		(cmpl_vld_i),
	.cmpl_rob_idx_i	(cmpl_rob_idx_i),
	.retire_vld_i	(retire_vld_o)
);

/* bench/rename_core_tb.sv */
// random rename testbench, every dispatch and retire of rename_core is checked against a model
`timescale 1ns/100ps
`include "rename_core_cfg.svh"

module rename_core_tb;
	import rename_pkg::*;

	logic						clk;
	logic						rst_n;
	logic						inst_vld;
	logic	[31:0]				inst_word;
	logic						cmpl_vld;
	logic	[`ROB_IDX_W-1:0]	cmpl_idx;
	logic						dsp_ack;
	logic	[`PREG_W-1:0]		opa_preg;
	logic	[`PREG_W-1:0]		opb_preg;
	logic	[`PREG_W-1:0]		dest_preg;
	logic	[`ROB_IDX_W-1:0]	rob_idx;
	logic						ret_vld;
	logic	[`AREG_W-1:0]		ret_areg;
	logic	[`PREG_W-1:0]		ret_preg;
	logic	[`PREG_W-1:0]		ret_free_preg;
	logic						ret_free_vld;

	// ==================================================
	// model state
	// ==================================================
	integer						seed = 36;
	logic	[`PREG_W-1:0]		map_m [`AREG_NUM];
	logic	[`PREG_W-1:0]		free_q [$];
	rob_entry_t					rob_q [$];		// oldest at front
	logic	[`ROB_IDX_W-1:0]	pend_idx [$];	// dispatched, not completed yet
	logic	[`ROB_IDX_W-1:0]	m_head;
	logic	[`ROB_IDX_W-1:0]	m_tail;
	logic	[31:0]				cur_word;
	logic						pending;		// word held until ack
	logic						hold_cmpl;		// withhold completions
	int							mode;			// 0 mix, 1 dest ops, 2 stores, 3 idle
	int							disp_cnt;
	int							store_no_tag;	// stores sent with free list empty

	clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

	rename_core i_rename_core (
		.clk				(clk),
		.rst_n_i			(rst_n),
		.inst_vld_i			(inst_vld),
		.inst_i				(inst_word),
		.dsp_ack_o			(dsp_ack),
		.dsp_opa_preg_o		(opa_preg),
		.dsp_opb_preg_o		(opb_preg),
		.dsp_dest_preg_o	(dest_preg),
		.dsp_rob_idx_o		(rob_idx),
		.cmpl_vld_i			(cmpl_vld),
		.cmpl_rob_idx_i		(cmpl_idx),
		.retire_vld_o		(ret_vld),
		.retire_areg_o		(ret_areg),
		.retire_preg_o		(ret_preg),
		.retire_free_preg_o	(ret_free_preg),
		.retire_free_vld_o	(ret_free_vld)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s: got %h, expected %h", name, got, exp);
			abort_run("value mismatch");
		end
	endtask

	// class and dest straight from the opcode table
	task automatic decode(input logic [31:0] w, output inst_class_e cls,
			output logic [`AREG_W-1:0] d, output logic hd);
		case (w[31:26])
			6'h10, 6'h11, 6'h12, 6'h13:	cls = CLASS_OP;
			6'h28, 6'h29:				cls = CLASS_LOAD;
			6'h2C, 6'h2D:				cls = CLASS_STORE;
			default:					cls = CLASS_OTHER;
		endcase
		d	= (cls == CLASS_OP) ? w[4:0] : w[25:21];	// rc or ra
		hd	= (cls == CLASS_OP || cls == CLASS_LOAD) && (d != `ZERO_REG);
	endtask

	function automatic logic [31:0] make_word(input int m);
		logic	[31:0]	w;
		logic	[31:0]	r;
		w = $random(seed);
		r = $random(seed);
		if (m == 1)
			r[4:3] = 2'd0;
		else if (m == 2)
			r[4:3] = 2'd2;
		case (r[4:3])
			2'd0:		w[31:26] = 6'h10 + {4'd0, r[1:0]};
			2'd1:		w[31:26] = {5'b10100, r[0]};	// 0x28 / 0x29
			2'd2:		w[31:26] = {5'b10110, r[0]};	// 0x2C / 0x2D
			default:	w[31:26] = r[1] ? 6'h1A : 6'h30;
		endcase
		if (m == 0 && r[7:5] == 3'd0) begin
			w[4:0]		= `ZERO_REG;	// some r31 dests
			w[25:21]	= `ZERO_REG;
		end
		if (m == 1 && w[4:0] == `ZERO_REG)
			w[4:0] = 5'd7;
		return w;
	endfunction

	// ==================================================
	// one clock: drive at rise, check and update at fall
	// ==================================================
	task automatic run_cycle();
		inst_class_e			cls;
		logic	[`AREG_W-1:0]	d;
		logic					hd;
		logic					exp_ack;
		logic					exp_ret;
		rob_entry_t				ent;
		logic	[31:0]			r;
		int						k;
		@(posedge clk);
		r = $random(seed);
		if (!pending && mode != 3 && r[1:0] != 2'b00) begin
			cur_word	= make_word(mode);
			pending		= 1'b1;
		end
		inst_vld	<= pending;
		inst_word	<= cur_word;
		cmpl_vld	<= 1'b0;
		if (!hold_cmpl && pend_idx.size() > 0 && r[2]) begin
			k			= int'($unsigned($random(seed)) % pend_idx.size());	// any order
			cmpl_vld	<= 1'b1;
			cmpl_idx	<= pend_idx[k];
			pend_idx.delete(k);
		end
		@(negedge clk);
		decode(inst_word, cls, d, hd);
		exp_ack = inst_vld && (rob_q.size() < `ROB_DEPTH) && (free_q.size() > 0 || !hd);
		exp_ret = 1'b0;
		if (rob_q.size() > 0)
			exp_ret = rob_q[0].done;	// completed in an earlier cycle
		check_eq("dsp_ack_o", 32'(dsp_ack), 32'(exp_ack));
		check_eq("retire_vld_o", 32'(ret_vld), 32'(exp_ret));
		if (exp_ret) begin
			check_eq("retire_free_vld_o", 32'(ret_free_vld), 32'(rob_q[0].has_dest));
			if (rob_q[0].has_dest) begin
				check_eq("retire_areg_o", 32'(ret_areg), 32'(rob_q[0].dest_areg));
				check_eq("retire_preg_o", 32'(ret_preg), 32'(rob_q[0].new_preg));
				check_eq("retire_free_preg_o", 32'(ret_free_preg), 32'(rob_q[0].old_preg));
			end
		end
		if (exp_ack) begin
			if (cls != CLASS_LOAD)	// load reads rb only
				check_eq("dsp_opa_preg_o", 32'(opa_preg), 32'(map_m[inst_word[25:21]]));
			check_eq("dsp_opb_preg_o", 32'(opb_preg), 32'(map_m[inst_word[20:16]]));
			check_eq("dsp_rob_idx_o", 32'(rob_idx), 32'(m_tail));
			if (hd)
				check_eq("dsp_dest_preg_o", 32'(dest_preg), 32'(free_q[0]));
		end
		// state after the closing edge
		if (cmpl_vld) begin
			k				= int'(`ROB_IDX_W'(cmpl_idx - m_head));
			ent				= rob_q[k];
			ent.done		= 1'b1;
			rob_q[k]		= ent;
		end
		if (exp_ack) begin
			ent				= '0;
			ent.dest_areg	= d;
			ent.has_dest	= hd;
			if (cls == CLASS_STORE && free_q.size() == 0)
				store_no_tag++;
			if (hd) begin
				ent.new_preg	= free_q.pop_front();
				ent.old_preg	= map_m[d];
				map_m[d]		= ent.new_preg;
			end
			rob_q.push_back(ent);
			pend_idx.push_back(m_tail);
			m_tail	= m_tail + `ROB_IDX_W'(1);
			pending	= 1'b0;
			disp_cnt++;
		end
		if (exp_ret) begin
			ent		= rob_q.pop_front();
			m_head	= m_head + `ROB_IDX_W'(1);
			if (ent.has_dest)
				free_q.push_back(ent.old_preg);	// Told goes back
		end
	endtask

	task automatic run_until_dispatched(input int n);
		int	start;
		int	tmo;
		start	= disp_cnt;
		tmo		= 0;
		while (disp_cnt - start < n) begin
			run_cycle();
			tmo++;
			if (tmo > 200)
				abort_run("timeout waiting for dispatches");
		end
	endtask

	task automatic drain();
		int	tmo;
		mode		= 3;
		hold_cmpl	= 1'b0;
		tmo			= 0;
		while (pending || rob_q.size() > 0) begin
			run_cycle();
			tmo++;
			if (tmo > 400)
				abort_run("timeout while draining the rob");
		end
	endtask

	initial begin
		int	tmo;
		inst_vld		= 1'b0;
		inst_word		= '0;
		cmpl_vld		= 1'b0;
		cmpl_idx		= '0;
		cur_word		= '0;
		pending			= 1'b0;
		hold_cmpl		= 1'b0;
		mode			= 0;
		disp_cnt		= 0;
		store_no_tag	= 0;
		m_head			= '0;
		m_tail			= '0;
		for (int i = 0; i < `AREG_NUM; i++)
			map_m[i] = `PREG_W'(i);	// identity after reset
		for (int i = `AREG_NUM; i < `PREG_NUM; i++)
			free_q.push_back(`PREG_W'(i));
		tmo = 0;
		while (rst_n !== 1'b1) begin
			@(negedge clk);
			tmo++;
			if (tmo > 20)
				abort_run("reset never released");
		end

		// tags run out first, then stores fill the rob
		hold_cmpl	= 1'b1;
		mode		= 1;
		run_until_dispatched(`PREG_NUM - `AREG_NUM);
		mode		= 2;
		run_until_dispatched(`ROB_DEPTH - (`PREG_NUM - `AREG_NUM));
		repeat (10) run_cycle();
		if (store_no_tag < 8 || rob_q.size() != `ROB_DEPTH || !pending)
			abort_run("rob full or empty free list not handled as expected");

		// free mix with completions in any order
		mode = 0;
		hold_cmpl = 1'b0;
		repeat (1000) run_cycle();
		drain();

		// dest op stalls on tags while rob still has room
		hold_cmpl	= 1'b1;
		mode		= 1;
		run_until_dispatched(`PREG_NUM - `AREG_NUM);
		repeat (10) run_cycle();
		if (rob_q.size() != 8 || !pending)
			abort_run("dest instruction dispatched without a free tag");
		drain();

		$display("Test passed");
		$finish;
	end

endmodule: rename_core_tb

/* rename_core.f */
+incdir+include
source/rename_pkg.sv
source/dispatch_if.sv
source/dispatch_stage.sv
source/map_table.sv
source/free_list.sv
source/rob.sv
source/rename_core.sv
bench/clk_gen.sv
bench/rename_core_assert.sv
bench/rename_core_tb.sv

/* Makefile */
TOP := rename_core_tb
OBJ := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f rename_core.f --top-module $(TOP) -Mdir $(OBJ)

# pass only when the run prints the pass line
run: build
	@out=$$(./$(OBJ)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only -Wall --timing --assert -f rename_core.f --top-module $(TOP)

clean:
	rm -rf $(OBJ)
